// File: Makefile
TOP := fe_top_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f fe_top.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: design/fe_ctl.sv
`timescale 1ns/1ps

module fe_ctl (
    input  logic              clk,
    input  logic              reset,
    input  logic              resume_fetch,
    input  logic              nuke,
    input  logic              br_mispred_valid,
    input  fe_pkg::t_rob_id   br_mispred_robid,
    input  fe_pkg::t_paddr    br_mispred_target,
    input  fe_pkg::t_rob_id   oldest_robid,
    output logic              fe_req_valid,
    output fe_pkg::t_paddr    fe_req_addr,
    input  logic              fb_rsp_valid,
    input  fe_pkg::t_rv_instr fb_rsp_instr,
    input  fe_pkg::t_paddr    fb_rsp_pc,
    output logic              valid_fe1,
    output fe_pkg::t_rv_instr instr_fe1,
    output fe_pkg::t_paddr    pc_fe1,
    input  logic              stall
);
    import fe_pkg::*;

    t_fsm_fe   state;
    t_fsm_fe   state_nxt;
    t_paddr    pc;
    logic      nuke_pdg;      // Mispredict held, nuke not seen yet
    t_rob_id   pdg_robid;     // ROB id of the held mispredict
    logic      flush_pdg;     // Fetch in flight belongs to the old path
    logic      mispred_ql;
    logic      go_nuke;
    t_rv_instr cap_instr;
    t_paddr    cap_pc;

    // Only an older branch may replace the held redirect
    assign mispred_ql = br_mispred_valid
                      & (~nuke_pdg | f_robid_a_older_b(br_mispred_robid, pdg_robid, oldest_robid));

    assign go_nuke = nuke_pdg | flush_pdg;

    always_comb begin
        state_nxt = state;
        case (state)
            FE_IDLE:      if (resume_fetch) state_nxt = FE_REQ_IC;
            FE_REQ_IC:    state_nxt = FE_PDG_IC;
            FE_PDG_IC: begin
                if (fb_rsp_valid) begin
                    if (go_nuke) state_nxt = FE_PDG_NUKE;       // Drop the stale response
                    else if (stall) state_nxt = FE_PDG_STALL;   // Hold it for decode
                end
            end
            FE_PDG_STALL: begin
                if (go_nuke) state_nxt = FE_PDG_NUKE;
                else if (!stall) state_nxt = FE_PDG_IC;
            end
            FE_PDG_NUKE:  if (resume_fetch) state_nxt = FE_REQ_IC;
            default:      state_nxt = FE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Next request goes out as soon as the current one is consumed
    assign fe_req_valid = (state == FE_REQ_IC)
                        | ((state == FE_PDG_IC) & fb_rsp_valid & ~go_nuke & ~stall)
                        | ((state == FE_PDG_STALL) & ~go_nuke & ~stall);
    assign fe_req_addr  = pc;

    // Redirect wins over the increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (mispred_ql) begin
            pc <= br_mispred_target;
        end else if (fe_req_valid) begin
            pc <= pc + t_paddr'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nuke_pdg <= 1'b0;
        end else if (mispred_ql) begin
            nuke_pdg <= 1'b1;
        end else if (nuke) begin
            nuke_pdg <= 1'b0;     // Clears the held mispredict too
        end
    end

    always_ff @(posedge clk) begin
        if (mispred_ql) pdg_robid <= br_mispred_robid;
    end

    // A fetch issued before the redirect must drain through FE_PDG_NUKE,
    // even when the nuke arrives before its response does
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_pdg <= 1'b0;
        end else if (state_nxt == FE_PDG_NUKE) begin
            flush_pdg <= 1'b0;
        end else if (mispred_ql && state != FE_IDLE && state != FE_PDG_NUKE) begin
            flush_pdg <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fb_rsp_valid) begin
            cap_instr <= fb_rsp_instr;
            cap_pc    <= fb_rsp_pc;
        end
    end

    // Live response in FE_PDG_IC, captured copy while stalled
    assign valid_fe1 = (((state == FE_PDG_IC) & fb_rsp_valid) | (state == FE_PDG_STALL))
                     & ~go_nuke & ~mispred_ql;
    assign instr_fe1 = (state == FE_PDG_STALL) ? cap_instr : fb_rsp_instr;
    assign pc_fe1    = (state == FE_PDG_STALL) ? cap_pc : fb_rsp_pc;

    // Held instruction may only vanish through a redirect
    a_hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        valid_fe1 && stall |=> !valid_fe1 || ($stable(instr_fe1) && $stable(pc_fe1)));

endmodule

// File: design/fe_pkg.sv
package fe_pkg;

    localparam int ADDR_W    = 12;     // Byte address and PC
    localparam int INSTR_W   = 32;
    localparam int MEM_WORDS = 1024;
    localparam int IDX_W     = 10;     // Word index, ADDR_W minus the byte offset
    localparam int ROB_W     = 5;

    typedef logic [ADDR_W-1:0]  t_paddr;
    typedef logic [INSTR_W-1:0] t_rv_instr;
    typedef logic [IDX_W-1:0]   t_word_idx;
    typedef logic [ROB_W-1:0]   t_rob_id;

    // Fetch controller states
    typedef enum logic [2:0] {
        FE_IDLE,        // Out of reset, waits for the first resume
        FE_REQ_IC,      // Issue a request at PC
        FE_PDG_IC,      // Request in flight
        FE_PDG_STALL,   // Response held until decode takes it
        FE_PDG_NUKE     // Redirected, waits for resume
    } t_fsm_fe;

    // ROB ids wrap, so age is the distance from the oldest id in flight.
    // Distances are taken modulo the ROB size by the 5-bit subtraction.
    function automatic logic f_robid_a_older_b(
        input t_rob_id a,
        input t_rob_id b,
        input t_rob_id oldest
    );
        t_rob_id dist_a;
        t_rob_id dist_b;
        dist_a = a - oldest;
        dist_b = b - oldest;
        return dist_a < dist_b;
    endfunction

endpackage

// File: design/fe_top.sv
`timescale 1ns/1ps

module fe_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              resume_fetch,
    input  logic              nuke,
    input  logic              br_mispred_valid,
    input  fe_pkg::t_rob_id   br_mispred_robid,
    input  fe_pkg::t_paddr    br_mispred_target,
    input  fe_pkg::t_rob_id   oldest_robid,
    input  logic              wr_valid,
    input  fe_pkg::t_word_idx wr_addr,
    input  fe_pkg::t_rv_instr wr_data,
    output logic              valid_fe1,
    output fe_pkg::t_rv_instr instr_fe1,
    output fe_pkg::t_paddr    pc_fe1,
    input  logic              stall
);
    import fe_pkg::*;

    logic      fe_req_valid;
    t_paddr    fe_req_addr;
    logic      fb_rsp_valid;
    t_rv_instr fb_rsp_instr;
    t_paddr    fb_rsp_pc;
    logic      rd_req;
    t_word_idx rd_addr;
    logic      rd_gnt;
    logic      mem_en;
    logic      mem_we;
    t_word_idx mem_addr;
    t_rv_instr mem_wdata;
    t_rv_instr mem_rdata;

    fe_ctl u_ctl (
        .clk, .reset, .resume_fetch, .nuke,
        .br_mispred_valid, .br_mispred_robid, .br_mispred_target, .oldest_robid,
        .fe_req_valid, .fe_req_addr,
        .fb_rsp_valid, .fb_rsp_instr, .fb_rsp_pc,
        .valid_fe1, .instr_fe1, .pc_fe1, .stall
    );

    fetch_buf u_fb (
        .clk, .reset, .fe_req_valid, .fe_req_addr,
        .rd_req, .rd_addr, .rd_gnt, .mem_rdata,
        .fb_rsp_valid, .fb_rsp_instr, .fb_rsp_pc
    );

    mem_arb u_arb (
        .clk, .reset, .wr_valid, .wr_addr, .wr_data,
        .rd_req, .rd_addr, .rd_gnt,
        .mem_en, .mem_we, .mem_addr, .mem_wdata
    );

    instr_mem u_mem (
        .clk, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

endmodule

// File: design/fetch_buf.sv
`timescale 1ns/1ps

module fetch_buf (
    input  logic              clk,
    input  logic              reset,
    input  logic              fe_req_valid,
    input  fe_pkg::t_paddr    fe_req_addr,
    output logic              rd_req,
    output fe_pkg::t_word_idx rd_addr,
    input  logic              rd_gnt,
    input  fe_pkg::t_rv_instr mem_rdata,
    output logic              fb_rsp_valid,
    output fe_pkg::t_rv_instr fb_rsp_instr,
    output fe_pkg::t_paddr    fb_rsp_pc
);
    import fe_pkg::*;

    logic   req_pdg;     // Waiting for the arbiter
    logic   rsp_due;     // Memory data lands this cycle
    t_paddr req_pc;

    always_ff @(posedge clk) begin
        if (fe_req_valid) req_pc <= fe_req_addr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pdg <= 1'b0;
        end else if (fe_req_valid) begin
            req_pdg <= 1'b1;
        end else if (rd_gnt) begin
            req_pdg <= 1'b0;
        end
    end

    // One cycle after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_due <= 1'b0;
        end else begin
            rsp_due <= rd_gnt;
        end
    end

    assign rd_req  = req_pdg;
    assign rd_addr = req_pc[ADDR_W-1:2];   // Drop byte offset

    assign fb_rsp_valid = rsp_due;
    assign fb_rsp_instr = mem_rdata;
    assign fb_rsp_pc    = req_pc;          // Still the old PC, a new request only latches at the edge

    // One fetch at a time, the controller must wait for the response
    a_single_outstanding: assert property (@(posedge clk) disable iff (reset)
        fe_req_valid |-> !req_pdg);

endmodule

// File: design/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
    input  logic              clk,
    input  logic              mem_en,
    input  logic              mem_we,
    input  fe_pkg::t_word_idx mem_addr,
    input  fe_pkg::t_rv_instr mem_wdata,
    output fe_pkg::t_rv_instr mem_rdata
);
    import fe_pkg::*;

    t_rv_instr mem_array [MEM_WORDS];

    // Read data registered, valid the cycle after the access.
    // A write cycle leaves the last read data in place.
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_array[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem_array[mem_addr];
            end
        end
    end

endmodule

// File: design/mem_arb.sv
`timescale 1ns/1ps

module mem_arb (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_valid,
    input  fe_pkg::t_word_idx wr_addr,
    input  fe_pkg::t_rv_instr wr_data,
    input  logic              rd_req,
    input  fe_pkg::t_word_idx rd_addr,
    output logic              rd_gnt,
    output logic              mem_en,
    output logic              mem_we,
    output fe_pkg::t_word_idx mem_addr,
    output fe_pkg::t_rv_instr mem_wdata
);

    // Boot writes have no back-pressure, so they always win
    assign rd_gnt    = rd_req & ~wr_valid;
    assign mem_en    = wr_valid | rd_req;
    assign mem_we    = wr_valid;
    assign mem_addr  = wr_valid ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;    // Ignored on reads

    // Losing reader keeps asking for the same word
    a_read_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_gnt |=> rd_req && $stable(rd_addr));

endmodule

// File: fe_top.f
design/fe_pkg.sv
design/fe_ctl.sv
design/fetch_buf.sv
design/mem_arb.sv
design/instr_mem.sv
design/fe_top.sv
verification/fe_top_tb.sv

// File: verification/fe_stimulus.txt
# W addr data | F addr count | S | E count | T stall_mode | I cycles
# M robid target oldest | N | R    (addr, data and ids hex, counts decimal)
F 000 768
W 000 00000013
W 004 00100093
W 008 00208113
W 00c 00310193
W 010 00418213
W 100 0ff00513
W 200 deadc0b7
W 340 12345037
I 4
S
E 12
T 1
E 20
T 2
E 16
T 0
# Redirect to 0x100, then nuke and resume
M 03 100 00
I 3
N
I 8
R
E 10
T 1
M 07 200 02
I 5
N
I 8
R
E 10
T 0
# Second id is younger and must not win
M 0a 300 04
M 0c 080 04
I 2
N
I 8
R
E 8
# Wrap, 1f is older than 01 when 1e is oldest
M 01 140 1e
M 1f 340 1e
N
I 8
R
E 8
# Boot writes to unused words while fetching
W c00 aaaa5555
E 2
F c40 6
E 4
T 2
W c80 5555aaaa
W c84 0f0f0f0f
E 6
F d00 10
E 6
T 0
E 4

// File: verification/fe_top_tb.sv
`timescale 1ns/1ps

module fe_top_tb;
    import fe_pkg::*;

    logic      clk;
    logic      reset;
    logic      resume_fetch;
    logic      nuke;
    logic      br_mispred_valid;
    t_rob_id   br_mispred_robid;
    t_paddr    br_mispred_target;
    t_rob_id   oldest_robid;
    logic      wr_valid;
    t_word_idx wr_addr;
    t_rv_instr wr_data;
    logic      valid_fe1;
    t_rv_instr instr_fe1;
    t_paddr    pc_fe1;
    logic      stall;

    t_rv_instr   shadow [MEM_WORDS];   // Everything written through the boot port
    t_paddr      exp_pc;
    logic        quiet;                // Nothing may reach decode
    logic        mp_pend;
    t_rob_id     mp_robid;
    t_paddr      mp_target;
    int          consumed;
    int          stall_mode;           // 0 off, 1 half, 2 heavy
    integer      seed;
    logic [31:0] rnd;

    fe_top UUT (
        .clk, .reset, .resume_fetch, .nuke,
        .br_mispred_valid, .br_mispred_robid, .br_mispred_target, .oldest_robid,
        .wr_valid, .wr_addr, .wr_data,
        .valid_fe1, .instr_fe1, .pc_fe1, .stall
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_pc(input t_paddr exp, input t_paddr act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %0t pc_fe1 expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_instr(input t_rv_instr exp, input t_rv_instr act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %0t instr_fe1 expected %h actual %h", $time, exp, act));
        end
    endtask

    // Age as distance from the oldest id, ROB of 32 entries
    function automatic int rob_dist(input t_rob_id id, input t_rob_id oldest);
        return (int'(id) - int'(oldest) + 32) % 32;
    endfunction

    // Stall pattern on the falling edge, outputs sampled once settled
    initial begin
        stall = 1'b0;
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            case (stall_mode)
                1:       stall = rnd[0];
                2:       stall = |rnd[1:0];
                default: stall = 1'b0;
            endcase
            #2;
            if (!reset && valid_fe1) begin
                if (quiet) begin
                    abort_run("an instruction reached decode while fetch was idle or redirected");
                end else begin
                    check_pc(exp_pc, pc_fe1);
                    check_instr(shadow[exp_pc[ADDR_W-1:2]], instr_fe1);
                    if (!stall) begin
                        exp_pc   = exp_pc + 12'd4;
                        consumed = consumed + 1;
                    end
                end
            end
        end
    end

    task automatic write_word(input t_paddr addr, input t_rv_instr data);
        @(negedge clk);
        wr_valid = 1'b1;
        wr_addr  = addr[ADDR_W-1:2];
        wr_data  = data;
        shadow[addr[ADDR_W-1:2]] = data;
    endtask

    task automatic end_write();
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    // Back-to-back writes, word value built from its own address
    task automatic fill_words(input t_paddr base, input int count);
        t_paddr addr;
        addr = base;
        for (int i = 0; i < count; i++) begin
            write_word(addr, {addr, 8'h13, ~addr});
            addr = addr + 12'd4;
        end
        end_write();
    endtask

    task automatic pulse_resume(input t_paddr restart);
        @(negedge clk);
        resume_fetch = 1'b1;
        exp_pc       = restart;
        quiet        = 1'b0;
        @(negedge clk);
        resume_fetch = 1'b0;
    endtask

    task automatic send_mispredict(input t_rob_id id, input t_paddr target, input t_rob_id oldest);
        @(negedge clk);
        br_mispred_valid  = 1'b1;
        br_mispred_robid  = id;
        br_mispred_target = target;
        oldest_robid      = oldest;
        quiet             = 1'b1;
        if (!mp_pend || rob_dist(id, oldest) < rob_dist(mp_robid, oldest)) begin
            mp_pend   = 1'b1;
            mp_robid  = id;
            mp_target = target;
        end
        @(negedge clk);
        br_mispred_valid = 1'b0;
    endtask

    task automatic pulse_nuke();
        @(negedge clk);
        nuke    = 1'b1;
        mp_pend = 1'b0;   // Target kept for the resume
        @(negedge clk);
        nuke = 1'b0;
    endtask

    task automatic wait_consumed(input int n);
        int target;
        int limit;
        int waited;
        target = consumed + n;
        limit  = 20 * n + 50;
        waited = 0;
        while (consumed < target && waited <= limit) begin
            @(posedge clk);
            waited++;
        end
        if (consumed < target) begin
            abort_run($sformatf("timed out waiting for %0d instructions, got %0d",
                                n, n - (target - consumed)));
        end
    endtask

    task automatic run_commands(input int fd);
        int               n;
        int               cnt;
        logic [7:0]       cmd;
        logic [31:0]      a1;
        logic [31:0]      a2;
        logic [31:0]      a3;
        logic [8*128-1:0] line_buf;
        n = $fscanf(fd, " %c", cmd);
        while (n == 1) begin
            case (cmd)
                "#": cnt = $fgets(line_buf, fd);
                "W": begin
                    cnt = $fscanf(fd, "%h %h", a1, a2);
                    write_word(a1[ADDR_W-1:0], a2);
                    end_write();
                end
                "F": begin
                    cnt = $fscanf(fd, "%h %d", a1, a2);
                    fill_words(a1[ADDR_W-1:0], int'(a2));
                end
                "S": pulse_resume(12'h000);          // Reset PC
                "E": begin
                    cnt = $fscanf(fd, "%d", a1);
                    wait_consumed(int'(a1));
                end
                "T": begin
                    cnt = $fscanf(fd, "%d", a1);
                    stall_mode = int'(a1);
                end
                "M": begin
                    cnt = $fscanf(fd, "%h %h %h", a1, a2, a3);
                    send_mispredict(a1[ROB_W-1:0], a2[ADDR_W-1:0], a3[ROB_W-1:0]);
                end
                "N": pulse_nuke();
                "R": pulse_resume(mp_target);
                "I": begin
                    cnt = $fscanf(fd, "%d", a1);
                    repeat (int'(a1)) @(negedge clk);
                end
                default: abort_run($sformatf("unknown stimulus command %c", cmd));
            endcase
            n = $fscanf(fd, " %c", cmd);
        end
    endtask

    initial begin
        int fd;
        reset             = 1'b1;
        resume_fetch      = 1'b0;
        nuke              = 1'b0;
        br_mispred_valid  = 1'b0;
        br_mispred_robid  = '0;
        br_mispred_target = '0;
        oldest_robid      = '0;
        wr_valid          = 1'b0;
        wr_addr           = '0;
        wr_data           = '0;
        exp_pc            = '0;
        quiet             = 1'b1;
        mp_pend           = 1'b0;
        mp_robid          = '0;
        mp_target         = '0;
        consumed          = 0;
        stall_mode        = 0;
        seed              = 32'hcc3b_5184;
        fd = $fopen("verification/fe_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file verification/fe_stimulus.txt");
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            run_commands(fd);
            $fclose(fd);
            $display("** PASS **");
            $finish;
        end
    end

endmodule
